// File: build.f
+incdir+src
src/mulPkg.sv
src/koggeStoneAdder.sv
src/partialProductStage.sv
src/adderTreeLevel.sv
src/signedMultiplier.sv
verif/signedMultiplierTb.sv

// File: src/adderTreeLevel.sv
`timescale 1ns/1ps
`default_nettype none

module adderTreeLevel
	import mulPkg::*;
#(
	parameter int inRows = 2
) (
	input  logic                           clk,
	input  logic                           arstN,
	input  productT [inRows-1:0]           rowsIn,
	input  logic                           validIn,
	output productT [(inRows+1)/2-1:0]     rowsOut,
	output logic                           validOut
);

	localparam int outRows = (inRows + 1) / 2;
	localparam int pairs = inRows / 2;

	wire productT [outRows-1:0] sums;

	if (inRows < 2) begin : inRowsCheck
		$error("adderTreeLevel needs at least two rows");
	end

	////////////////////////////////////////////////////////////////////////////
	// Pairwise adders
	////////////////////////////////////////////////////////////////////////////

	for (genvar k = 0; k < pairs; k++) begin : pairGen
		koggeStoneAdder #(
			.width($bits(productT))
		) pairAdd (
			.a  (rowsIn[2*k]),
			.b  (rowsIn[2*k+1]),
			.sum(sums[k])
		);
	end

	// Odd row out goes straight to the next level
	if (inRows % 2 == 1) begin : oddRow
		assign sums[outRows-1] = rowsIn[inRows-1];
	end

	////////////////////////////////////////////////////////////////////////////
	// Level register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		rowsOut <= sums;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validOut <= 1'b0;
		end else begin
			validOut <= validIn;
		end
	end

	// Strobe advances exactly one level per cycle
	validFollows: assert property (
		@(posedge clk) disable iff (!arstN)
		$past(arstN) |-> (validOut == $past(validIn))
	) else $error("validOut does not follow validIn by one cycle");

endmodule

`default_nettype wire

// File: src/koggeStoneAdder.sv
`timescale 1ns/1ps
`default_nettype none

module koggeStoneAdder #(
	parameter int width = 48
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] sum
);

	localparam int levels = $clog2(width);

	// Group generate and propagate after each prefix level
	logic [levels:0][width-1:0] genL;
	logic [levels:0][width-1:0] propL;
	logic [width-1:0] carry;

	////////////////////////////////////////////////////////////////////////////
	// Prefix network
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		genL[0] = a & b;
		propL[0] = a ^ b;
		for (int l = 0; l < levels; l++) begin
			for (int i = 0; i < width; i++) begin
				if (i >= (1 << l)) begin
					// Black cell, span doubles each level
					genL[l+1][i] = genL[l][i] | (propL[l][i] & genL[l][i-(1<<l)]);
					propL[l+1][i] = propL[l][i] & propL[l][i-(1<<l)];
				end else begin
					genL[l+1][i] = genL[l][i];
					propL[l+1][i] = propL[l][i];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sum
	////////////////////////////////////////////////////////////////////////////

	// Carry into bit i is the group generate of bits i-1 down to 0
	assign carry = {genL[levels][width-2:0], 1'b0};

	// Carry out of the top bit is dropped, the sum wraps modulo 2^width
	assign sum = propL[0] ^ carry;

endmodule

`default_nettype wire

// File: src/mulConfig_config.svh
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

`define MUL_OPERAND_WIDTH 24
`define MUL_PRODUCT_WIDTH 48

////////////////////////////////////////////////////////////////////////////
// Reduction tree shape
////////////////////////////////////////////////////////////////////////////

// One row per multiplier bit plus the correction row
`define MUL_PP_ROWS 25

// 25 -> 13 -> 7 -> 4 -> 2 -> 1
`define MUL_TREE_LEVELS 5

// Partial-product register plus one register per tree level
`define MUL_LATENCY 6

`endif

// File: src/mulPkg.sv
`default_nettype none

`include "mulConfig_config.svh"

package mulPkg;

	////////////////////////////////////////////////////////////////////////////
	// Words
	////////////////////////////////////////////////////////////////////////////

	// Two's-complement operand
	typedef logic signed [`MUL_OPERAND_WIDTH-1:0] operandT;

	// Full product, also the width of every tree row
	typedef logic [`MUL_PRODUCT_WIDTH-1:0] productT;

	////////////////////////////////////////////////////////////////////////////
	// Pipeline bundles
	////////////////////////////////////////////////////////////////////////////

	// Operand pair taken on every clock edge where valid is high
	typedef struct packed {
		logic    valid;
		operandT multiplicand;
		operandT multiplier;
	} operandPairT;

	// Result leaving the last tree level
	typedef struct packed {
		logic    valid;
		productT product;
	} productResultT;

endpackage

`default_nettype wire

// File: src/partialProductStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulConfig_config.svh"

module partialProductStage
	import mulPkg::*;
(
	input  logic                        clk,
	input  logic                        arstN,
	input  operandPairT                 operands,
	output productT [`MUL_PP_ROWS-1:0] rows,
	output logic                        rowsValid
);

	localparam int opW = `MUL_OPERAND_WIDTH;

	// Baugh-Wooley constant, ones at bit n and bit 2n-1
	localparam productT corrRow = (productT'(1) << (2*opW-1)) | (productT'(1) << opW);

	productT [`MUL_PP_ROWS-1:0] rowsNext;

	////////////////////////////////////////////////////////////////////////////
	// Row generation
	////////////////////////////////////////////////////////////////////////////

	// Row for multiplier bit i, already shifted into place
	function automatic productT ppRow(
		input operandT mcand,
		input logic    mBit,
		input int      i
	);
		logic [opW-1:0] bits;
		bits = mcand & {opW{mBit}};
		// Terms pairing exactly one sign bit are inverted
		if (i == opW-1) begin
			bits[opW-2:0] = ~bits[opW-2:0];
		end else begin
			bits[opW-1] = ~bits[opW-1];
		end
		return productT'(bits) << i;
	endfunction

	always_comb begin
		for (int i = 0; i < opW; i++) begin
			rowsNext[i] = ppRow(operands.multiplicand, operands.multiplier[i], i);
		end
		rowsNext[`MUL_PP_ROWS-1] = corrRow;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		rows <= rowsNext;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rowsValid <= 1'b0;
		end else begin
			rowsValid <= operands.valid;
		end
	end

	// Strobe from the outside must be clean once out of reset
	rowsValidKnown: assert property (
		@(posedge clk) disable iff (!arstN)
		!$isunknown(rowsValid)
	) else $error("rowsValid is unknown");

	if (`MUL_PP_ROWS != opW + 1) begin : rowCountCheck
		$error("MUL_PP_ROWS must equal operand width plus one");
	end

endmodule

`default_nettype wire

// File: src/signedMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulConfig_config.svh"

module signedMultiplier
	import mulPkg::*;
(
	input  logic          clk,
	input  logic          arstN,
	input  operandPairT   operands,
	output productResultT result
);

	// Rows and strobe leaving each stage
	productT [`MUL_PP_ROWS-1:0] rows0;
	productT [12:0] rows1;
	productT [6:0] rows2;
	productT [3:0] rows3;
	productT [1:0] rows4;
	productT [0:0] rows5;
	logic valid0;
	logic valid1;
	logic valid2;
	logic valid3;
	logic valid4;
	logic valid5;

	////////////////////////////////////////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////////////////////////////////////////

	partialProductStage ppStage (
		.clk      (clk),
		.arstN    (arstN),
		.operands (operands),
		.rows     (rows0),
		.rowsValid(valid0)
	);

	adderTreeLevel #(.inRows(`MUL_PP_ROWS)) level0 (
		.clk(clk), .arstN(arstN),
		.rowsIn(rows0), .validIn(valid0), .rowsOut(rows1), .validOut(valid1)
	);

	adderTreeLevel #(.inRows(13)) level1 (
		.clk(clk), .arstN(arstN),
		.rowsIn(rows1), .validIn(valid1), .rowsOut(rows2), .validOut(valid2)
	);

	adderTreeLevel #(.inRows(7)) level2 (
		.clk(clk), .arstN(arstN),
		.rowsIn(rows2), .validIn(valid2), .rowsOut(rows3), .validOut(valid3)
	);

	adderTreeLevel #(.inRows(4)) level3 (
		.clk(clk), .arstN(arstN),
		.rowsIn(rows3), .validIn(valid3), .rowsOut(rows4), .validOut(valid4)
	);

	adderTreeLevel #(.inRows(2)) level4 (
		.clk(clk), .arstN(arstN),
		.rowsIn(rows4), .validIn(valid4), .rowsOut(rows5), .validOut(valid5)
	);

	assign result = '{valid: valid5, product: rows5[0]};

	if (`MUL_LATENCY != `MUL_TREE_LEVELS + 1) begin : latencyCheck
		$error("MUL_LATENCY must be MUL_TREE_LEVELS plus one");
	end

endmodule

`default_nettype wire

// File: verif/signedMultiplierTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulConfig_config.svh"

module signedMultiplierTb
	import mulPkg::*;
();

	localparam int latency = `MUL_LATENCY;
	localparam int waitLimit = `MUL_LATENCY + 4;

	// Extremes of the operand range
	localparam operandT minOp = operandT'(24'h800000);
	localparam operandT maxOp = operandT'(24'h7FFFFF);

	logic clk;
	logic arstN;
	operandPairT operands;
	productResultT result;

	int seed = 48;
	int productErrors = 0;
	int validErrors = 0;
	int timeoutErrors = 0;

	// Cycles since arstN went high, saturating at the latency
	int cyclesUp;

	signedMultiplier UUT (
		.clk     (clk),
		.arstN   (arstN),
		.operands(operands),
		.result  (result)
	);

	always #20 clk = ~clk;

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cyclesUp <= 0;
		end else if (cyclesUp < latency) begin
			cyclesUp <= cyclesUp + 1;
		end
	end

	// Reference product, both operands sign-extended to the full width
	function automatic productT signedProduct(input operandT a, input operandT b);
		logic signed [`MUL_PRODUCT_WIDTH-1:0] p;
		p = a * b;
		return productT'(p);
	endfunction

	function automatic operandT randomOperand();
		return operandT'($random(seed));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	quietInReset: assert property (
		@(posedge clk) !arstN |-> !result.valid
	) else begin
		validErrors++;
		$display("** Error at %0t: result.valid expected 0, got %b",
			$time, $sampled(result.valid));
	end

	// Pipeline still holds nothing accepted since release
	noStaleResult: assert property (
		@(posedge clk) disable iff (!arstN)
		(cyclesUp < latency) |-> !result.valid
	) else begin
		validErrors++;
		$display("** Error at %0t: result.valid expected 0, got %b",
			$time, $sampled(result.valid));
	end

	validTracks: assert property (
		@(posedge clk) disable iff (!arstN)
		(cyclesUp >= latency) |-> (result.valid == $past(operands.valid, latency))
	) else begin
		validErrors++;
		$display("** Error at %0t: result.valid expected %b, got %b",
			$time, $past(operands.valid, latency), $sampled(result.valid));
	end

	productCorrect: assert property (
		@(posedge clk) disable iff (!arstN)
		result.valid |-> (result.product == signedProduct(
			$past(operands.multiplicand, latency), $past(operands.multiplier, latency)))
	) else begin
		productErrors++;
		$display("** Error at %0t: result.product expected %h, got %h",
			$time,
			signedProduct($past(operands.multiplicand, latency),
				$past(operands.multiplier, latency)),
			$sampled(result.product));
	end

	// Async reset must clear the output strobe without waiting for a clock
	always @(negedge arstN) begin
		#1;
		resetDropsValid: assert (!result.valid) else begin
			validErrors++;
			$display("** Error at %0t: result.valid expected 0, got %b",
				$time, result.valid);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic drivePair(input operandT a, input operandT b, input logic v);
		@(posedge clk);
		operands <= '{valid: v, multiplicand: a, multiplier: b};
	endtask

	// Random data with valid low, must never show up at the output
	task automatic driveIdle();
		drivePair(randomOperand(), randomOperand(), 1'b0);
	endtask

	task automatic waitForResult();
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < waitLimit) begin
			@(negedge clk);
			seen = result.valid;
			cycles++;
		end
		if (!seen) begin
			timeoutErrors++;
			$display("Timed out after %0d cycles waiting for result.valid", waitLimit);
		end
	endtask

	task automatic runCorner(input operandT a, input operandT b);
		drivePair(a, b, 1'b1);
		driveIdle();
		waitForResult();
	endtask

	task automatic runStream(input int count, input bit gaps);
		logic v;
		repeat (count) begin
			v = gaps ? (($random(seed) & 3) != 0) : 1'b1;
			drivePair(randomOperand(), randomOperand(), v);
		end
		repeat (latency + 2) begin
			driveIdle();
		end
	endtask

	task automatic runResetInFlight();
		repeat (latency + 2) begin
			drivePair(randomOperand(), randomOperand(), 1'b1);
		end
		// Results are leaving the pipeline when reset hits
		drivePair(randomOperand(), randomOperand(), 1'b1);
		arstN <= 1'b0;
		repeat (2) begin
			drivePair(randomOperand(), randomOperand(), 1'b1);
		end
		driveIdle();
		arstN <= 1'b1;
		repeat (2) begin
			driveIdle();
		end
		runCorner(randomOperand(), randomOperand());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		arstN = 1'b1;
		operands = '0;
		#1;
		arstN = 1'b0;

		// Valid pairs during reset are dropped
		repeat (3) begin
			drivePair(randomOperand(), randomOperand(), 1'b1);
		end
		driveIdle();
		arstN <= 1'b1;
		repeat (2) begin
			driveIdle();
		end

		runCorner(24'sd0, randomOperand());
		runCorner(randomOperand(), 24'sd0);
		runCorner(24'sd1, -24'sd1);
		runCorner(-24'sd1, -24'sd1);
		runCorner(minOp, minOp);
		runCorner(minOp, maxOp);
		runCorner(maxOp, maxOp);

		runStream(200, 1'b0);
		runStream(200, 1'b1);
		runResetInFlight();
		runStream(50, 1'b1);

		$display("Errors: %0d product, %0d valid, %0d timeout",
			productErrors, validErrors, timeoutErrors);
		if (productErrors + validErrors + timeoutErrors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
